// File: verilog/daa_pkg.sv
package daa_pkg;

  // Reserved broadcast address 7E with the read bit set
  localparam logic [7:0] RSVD_BYTE = 8'hFD;

  // PID (48) + BCR (8) + DCR (8)
  localparam logic [6:0] ID_BITS = 7'd64;

  typedef enum logic [3:0] {
    Idle            = 4'h0,
    WaitStart       = 4'h1,
    ReceiveRsvdByte = 4'h2,
    AckRsvdByte     = 4'h3,
    SendNack        = 4'h4,
    SendID          = 4'h5,
    PrepareIDBit    = 4'h6,
    SendIDBit       = 4'h7,
    LostArbitration = 4'h8,
    ReceiveAddr     = 4'h9,
    AckAddr         = 4'ha,
    Done            = 4'hb,
    Error           = 4'hc
  } daa_state_e;

  // Bit transmitter phases
  typedef enum logic [1:0] {
    TxWaitFall = 2'd0,
    TxDrive    = 2'd1,
    TxSample   = 2'd2,
    TxFinish   = 2'd3
  } tx_phase_e;

  typedef struct packed {
    logic scl_rise;
    logic scl_fall;
    logic start;
    logic rstart;
    logic stop;
    logic sda;
  } bus_events_t;

  // value of 1 releases SDA
  typedef struct packed {
    logic req_bit;
    logic value;
  } tx_req_t;

  typedef struct packed {
    logic [7:0] data;
    logic       done;
  } rx_resp_t;

endpackage

// File: verilog/bus_monitor.sv
`timescale 1ns/1ps

module bus_monitor
  import daa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output bus_events_t events_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_prev_q;
  logic       sda_prev_q;
  logic       busy_q;
  logic       scl_high;
  logic       sda_fall;
  logic       sda_rise;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_sync_q[1];
      sda_prev_q <= sda_sync_q[1];
    end
  end

  assign scl_high = scl_sync_q[1] & scl_prev_q;
  assign sda_fall = ~sda_sync_q[1] & sda_prev_q;
  assign sda_rise = sda_sync_q[1] & ~sda_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (scl_high && sda_rise) begin
      busy_q <= 1'b0;
    end else if (scl_high && sda_fall) begin
      busy_q <= 1'b1;
    end
  end

  assign events_o.scl_rise = scl_sync_q[1] & ~scl_prev_q;
  assign events_o.scl_fall = ~scl_sync_q[1] & scl_prev_q;
  assign events_o.start    = scl_high & sda_fall & ~busy_q;
  assign events_o.rstart   = scl_high & sda_fall & busy_q;
  assign events_o.stop     = scl_high & sda_rise;
  assign events_o.sda      = sda_sync_q[1];

endmodule

// File: verilog/bus_rx.sv
`timescale 1ns/1ps

module bus_rx
  import daa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  bus_events_t events_i,
  input  logic        rx_req_i,
  output rx_resp_t    rx_o
);

  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       done_q;
  logic       clear;
  logic       sample;

  // Any frame boundary or dropped request restarts the byte
  assign clear  = events_i.start | events_i.rstart | events_i.stop | ~rx_req_i;
  assign sample = rx_req_i & events_i.scl_rise;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      done_q    <= 1'b0;
    end else if (clear) begin
      bit_cnt_q <= '0;
      done_q    <= 1'b0;
    end else if (sample) begin
      // Counter wraps to zero after the eighth bit
      bit_cnt_q <= bit_cnt_q + 3'd1;
      done_q    <= (bit_cnt_q == 3'd7);
    end else begin
      done_q    <= 1'b0;
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[6:0], events_i.sda};
    end
  end

  assign rx_o.data = shift_q;
  assign rx_o.done = done_q;

endmodule

// File: verilog/bus_tx.sv
`timescale 1ns/1ps

module bus_tx
  import daa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  bus_events_t events_i,
  input  tx_req_t     tx_req_i,
  output logic        sda_oe_o,
  output logic        tx_done_o,
  output logic        arb_lost_o
);

  tx_phase_e phase_q;
  logic      scl_low_q;
  logic      oe_q;
  logic      lost_q;
  logic      bus_reset;

  assign bus_reset = events_i.start | events_i.rstart | events_i.stop;

  // Tracks the SCL low phase so back-to-back bits need no extra fall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_low_q <= 1'b0;
    end else if (events_i.scl_fall) begin
      scl_low_q <= 1'b1;
    end else if (events_i.scl_rise) begin
      scl_low_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= TxWaitFall;
      oe_q    <= 1'b0;
      lost_q  <= 1'b0;
    end else if (bus_reset) begin
      phase_q <= TxWaitFall;
      oe_q    <= 1'b0;
      lost_q  <= 1'b0;
    end else begin
      unique case (phase_q)
        TxWaitFall: begin
          if (tx_req_i.req_bit && (events_i.scl_fall || scl_low_q)) begin
            phase_q <= TxDrive;
          end
        end
        TxDrive: begin
          oe_q    <= ~tx_req_i.value;
          lost_q  <= 1'b0;
          phase_q <= TxSample;
        end
        TxSample: begin
          if (events_i.scl_rise) begin
            // Released but someone else pulled the line low
            lost_q  <= tx_req_i.value & ~events_i.sda;
            phase_q <= TxFinish;
          end
        end
        TxFinish: begin
          if (events_i.scl_fall) begin
            oe_q    <= 1'b0;
            phase_q <= TxWaitFall;
          end
        end
        default: begin
          phase_q <= TxWaitFall;
        end
      endcase
    end
  end

  assign sda_oe_o   = oe_q;
  assign tx_done_o  = (phase_q == TxFinish) & events_i.scl_fall;
  assign arb_lost_o = tx_done_o & lost_q;

endmodule

// File: verilog/ccc_entdaa.sv
`timescale 1ns/1ps

module ccc_entdaa
  import daa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [47:0] id_i,
  input  logic [7:0]  dcr_i,
  input  logic [7:0]  bcr_i,
  input  logic        start_daa_i,
  input  bus_events_t events_i,
  input  rx_resp_t    rx_i,
  input  logic        tx_done_i,
  input  logic        arb_lost_i,
  output logic        done_daa_o,
  output logic        rx_req_o,
  output tx_req_t     tx_req_o,
  output logic [6:0]  address_o,
  output logic        address_valid_o
);

  daa_state_e  state_q;
  daa_state_e  state_d;
  logic [6:0]  id_bit_count;
  logic        load_id_counter;
  logic        tick_id_counter;
  logic        rsvd_byte_det;
  logic [63:0] device_id;
  logic        parity_ok;

  assign rsvd_byte_det = (rx_i.data == RSVD_BYTE);
  assign device_id     = {id_i, bcr_i, dcr_i};

  // Odd parity over address and parity bit together
  assign parity_ok = ^rx_i.data;

  assign done_daa_o = (state_q == Done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_bit_count <= '0;
    end else if (load_id_counter) begin
      id_bit_count <= ID_BITS;
    end else if (tick_id_counter) begin
      id_bit_count <= id_bit_count - 7'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (start_daa_i) begin
          state_d = WaitStart;
        end
      end
      WaitStart: begin
        if (events_i.rstart) begin
          state_d = ReceiveRsvdByte;
        end
      end
      ReceiveRsvdByte: begin
        if (rx_i.done) begin
          state_d = rsvd_byte_det ? AckRsvdByte : SendNack;
        end
      end
      AckRsvdByte: begin
        if (tx_done_i) begin
          state_d = SendID;
        end
      end
      SendNack: begin
        if (tx_done_i) begin
          state_d = Error;
        end
      end
      SendID: begin
        state_d = PrepareIDBit;
      end
      PrepareIDBit: begin
        state_d = SendIDBit;
      end
      SendIDBit: begin
        if (tx_done_i) begin
          // Another target won this bit
          if (arb_lost_i) begin
            state_d = LostArbitration;
          end else if (id_bit_count == '0) begin
            state_d = ReceiveAddr;
          end else begin
            state_d = PrepareIDBit;
          end
        end
      end
      LostArbitration: begin
        state_d = Error;
      end
      ReceiveAddr: begin
        if (rx_i.done) begin
          state_d = parity_ok ? AckAddr : SendNack;
        end
      end
      AckAddr: begin
        if (tx_done_i) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Idle;
      end
      Error: begin
        // Left only by STOP
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_comb begin
    rx_req_o         = 1'b0;
    tx_req_o.req_bit = 1'b0;
    tx_req_o.value   = 1'b1;
    load_id_counter  = 1'b0;
    tick_id_counter  = 1'b0;
    address_o        = '0;
    address_valid_o  = 1'b0;
    unique case (state_q)
      ReceiveRsvdByte: begin
        rx_req_o = 1'b1;
      end
      AckRsvdByte: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 1'b0;
      end
      SendNack: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 1'b1;
      end
      SendID: begin
        load_id_counter = 1'b1;
      end
      PrepareIDBit: begin
        tick_id_counter = 1'b1;
      end
      SendIDBit: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = device_id[id_bit_count[5:0]];
      end
      ReceiveAddr: begin
        rx_req_o = 1'b1;
        if (rx_i.done && parity_ok) begin
          address_o       = rx_i.data[7:1];
          address_valid_o = 1'b1;
        end
      end
      AckAddr: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 1'b0;
      end
      default: begin
      end
    endcase
  end

  // STOP ends any sequence in progress
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (events_i.stop && (state_q != Idle)) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: verilog/daa_target_top.sv
`timescale 1ns/1ps

module daa_target_top
  import daa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        sda_oe_o,
  input  logic [47:0] pid_i,
  input  logic [7:0]  bcr_i,
  input  logic [7:0]  dcr_i,
  input  logic        start_daa_i,
  output logic        done_daa_o,
  output logic [6:0]  dyn_addr_o,
  output logic        dyn_addr_valid_o
);

  bus_events_t events;
  rx_resp_t    rx_resp;
  tx_req_t     tx_req;
  logic        rx_req;
  logic        tx_done;
  logic        arb_lost;

  bus_monitor i_bus_monitor (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .scl_i    (scl_i),
    .sda_i    (sda_i),
    .events_o (events)
  );

  bus_rx i_bus_rx (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .events_i (events),
    .rx_req_i (rx_req),
    .rx_o     (rx_resp)
  );

  // Open drain only and SCL is never driven
  bus_tx i_bus_tx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .events_i   (events),
    .tx_req_i   (tx_req),
    .sda_oe_o   (sda_oe_o),
    .tx_done_o  (tx_done),
    .arb_lost_o (arb_lost)
  );

  ccc_entdaa i_ccc_entdaa (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .id_i            (pid_i),
    .dcr_i           (dcr_i),
    .bcr_i           (bcr_i),
    .start_daa_i     (start_daa_i),
    .events_i        (events),
    .rx_i            (rx_resp),
    .tx_done_i       (tx_done),
    .arb_lost_i      (arb_lost),
    .done_daa_o      (done_daa_o),
    .rx_req_o        (rx_req),
    .tx_req_o        (tx_req),
    .address_o       (dyn_addr_o),
    .address_valid_o (dyn_addr_valid_o)
  );

endmodule

// File: verification/daa_tb_tasks.svh
`ifndef DAA_TB_TASKS_SVH
`define DAA_TB_TASKS_SVH

// Every drive lands 10 ns after a rising edge
task automatic wait_clocks(input int n);
  repeat (n) @(posedge clk);
  #10;
endtask

// Starts from an idle bus with both lines high
task automatic start_condition();
  sda_ctl = 1'b0;
  wait_clocks(QUARTER);
  scl = 1'b0;
endtask

task automatic repeated_start();
  wait_clocks(QUARTER);
  sda_ctl = 1'b1;
  wait_clocks(QUARTER);
  scl = 1'b1;
  wait_clocks(QUARTER);
  sda_ctl = 1'b0;
  wait_clocks(QUARTER);
  scl = 1'b0;
endtask

task automatic stop_condition();
  wait_clocks(QUARTER);
  sda_ctl = 1'b0;
  wait_clocks(QUARTER);
  scl = 1'b1;
  wait_clocks(QUARTER);
  sda_ctl = 1'b1;
  wait_clocks(QUARTER);
endtask

// One SCL period where a drive of 1 releases SDA
task automatic clock_bit(input logic drive, output logic sampled);
  wait_clocks(QUARTER);
  sda_ctl = drive;
  wait_clocks(QUARTER);
  scl = 1'b1;
  wait_clocks(QUARTER);
  sampled = sda_bus;
  wait_clocks(QUARTER);
  scl = 1'b0;
endtask

// MSB first with the ninth bit released for the ACK
task automatic write_byte(input logic [7:0] data, output logic ack);
  logic [7:0] rest;
  logic       unused;
  rest = data;
  repeat (8) begin
    clock_bit(rest[7], unused);
    rest = {rest[6:0], 1'b0};
  end
  clock_bit(1'b1, ack);
endtask

// With contend set, pull SDA low on the first 1 of the ID
task automatic read_id(input logic [63:0] id, input logic contend, output logic [63:0] got);
  logic [63:0] rest;
  logic        pulled;
  logic        drive;
  logic        b;
  rest   = id;
  pulled = 1'b0;
  got    = '0;
  repeat (64) begin
    drive  = ~(contend & ~pulled & rest[63]);
    pulled = pulled | ~drive;
    clock_bit(drive, b);
    got  = {got[62:0], b};
    rest = {rest[62:0], 1'b0};
  end
endtask

// Odd parity over address and parity bit
function automatic logic [7:0] addr_byte(input logic [6:0] addr, input logic good);
  return {addr, good ? ~(^addr) : ^addr};
endfunction

task automatic wait_for_done(input int base);
  int n;
  n = 0;
  while (done_pulses == base && n < DONE_WAIT) begin
    wait_clocks(1);
    n++;
  end
  if (done_pulses == base) begin
    errors++;
    $display("%s: no done pulse within %0d cycles of STOP", test_name, DONE_WAIT);
  end
endtask

// START, hand-off, Sr, reserved byte, ID, address, STOP
task automatic run_daa(input logic [63:0] id, input logic [7:0] first, input logic contend,
                       input logic [7:0] addr_frame, input logic exp_rsvd_ack,
                       input logic [63:0] exp_id, input logic exp_addr_ack);
  logic        ack;
  logic [63:0] got;
  int          done_base;
  int          strobe_base;
  done_base       = done_pulses;
  strobe_base     = strobes;
  {pid, bcr, dcr} = id;
  start_condition();
  start_daa = 1'b1;
  wait_clocks(1);
  start_daa = 1'b0;
  repeated_start();
  write_byte(first, ack);
  check_bit("reserved byte ack", exp_rsvd_ack, ack);
  read_id(id, contend, got);
  check_id("id bits", exp_id, got);
  write_byte(addr_frame, ack);
  check_bit("address ack", exp_addr_ack, ack);
  stop_condition();
  wait_for_done(done_base);
  wait_clocks(HALF_CLKS);
  check_state_flag("single done pulse", 1'b1, done_pulses == done_base + 1);
  // Only an ACKed address strobes
  check_state_flag("address strobe", ~exp_addr_ack, strobes != strobe_base);
  if (!exp_addr_ack) begin
    check_state_flag("single address strobe", 1'b1, strobes == strobe_base + 1);
    check_byte("dynamic address", addr_frame[7:1], strobe_addr);
  end
endtask

task automatic idle_before_daa();
  logic ack;
  int   base;
  test_name = "idle_before_daa";
  base      = done_pulses;
  check_state_flag("sda_oe after reset", 1'b0, sda_oe);
  check_state_flag("done after reset", 1'b0, done_daa);
  check_state_flag("valid after reset", 1'b0, dyn_addr_valid);
  start_condition();
  write_byte(RSVD_BYTE, ack);
  check_bit("ack while idle", 1'b1, ack);
  stop_condition();
  wait_clocks(HALF_CLKS);
  check_state_flag("done while idle", 1'b0, done_pulses != base);
endtask

task automatic fixed_id_daa();
  test_name = "fixed_id_daa";
  run_daa(FIXED_ID, RSVD_BYTE, 1'b0, addr_byte(7'h3a, 1'b1), 1'b0, FIXED_ID, 1'b0);
endtask

// 7C with the read bit
task automatic wrong_rsvd_byte();
  test_name = "wrong_rsvd_byte";
  run_daa(FIXED_ID, 8'hf9, 1'b0, addr_byte(7'h2b, 1'b1), 1'b1, '1, 1'b1);
endtask

// Zeros up to the contended bit 56 and ones after it
task automatic lost_arbitration();
  test_name = "lost_arbitration";
  run_daa(FIXED_ID, RSVD_BYTE, 1'b1, addr_byte(7'h2b, 1'b1), 1'b0,
          64'h00ff_ffff_ffff_ffff, 1'b1);
endtask

task automatic bad_parity();
  test_name = "bad_parity";
  run_daa(FIXED_ID, RSVD_BYTE, 1'b0, addr_byte(7'h51, 1'b0), 1'b0, FIXED_ID, 1'b1);
endtask

task automatic random_ids();
  logic [31:0] hi;
  logic [31:0] lo;
  logic [31:0] addr;
  logic [63:0] id;
  test_name = "random_ids";
  repeat (3) begin
    hi   = $urandom;
    lo   = $urandom;
    // Dynamic addresses 08 to 77
    addr = $urandom % 32'd112 + 32'd8;
    id   = {hi, lo};
    run_daa(id, RSVD_BYTE, 1'b0, addr_byte(addr[6:0], 1'b1), 1'b0, id, 1'b0);
  end
endtask

`endif

// File: verification/daa_tb.sv
`timescale 1ns/1ps

module daa_tb
  import daa_pkg::*;
();

  localparam int CLK_NS    = 100;
  localparam int HALF_CLKS = 8;
  localparam int QUARTER   = HALF_CLKS / 2;
  localparam int SCL_NS    = 2 * HALF_CLKS * CLK_NS;
  localparam int DONE_WAIT = 4 * HALF_CLKS;
  // Six tests of about 100 SCL periods with twice the margin
  localparam int WATCHDOG_NS = 2 * 6 * 100 * SCL_NS;

  // PID then BCR then DCR with the first 1 of the ID at bit 56
  localparam logic [63:0] FIXED_ID = {48'h0123_4567_89ab, 8'h26, 8'hc3};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        scl;
  logic        sda_ctl;
  logic        sda_bus;
  logic        sda_oe;
  logic [47:0] pid;
  logic [7:0]  bcr;
  logic [7:0]  dcr;
  logic        start_daa;
  logic        done_daa;
  logic [6:0]  dyn_addr;
  logic        dyn_addr_valid;

  int          errors;
  int          checks;
  int          done_pulses;
  int          strobes;
  logic [6:0]  strobe_addr;
  string       test_name;

  always #(CLK_NS / 2) clk = ~clk;

  // Open drain bus where low wins
  assign sda_bus = sda_ctl & ~sda_oe;

  daa_target_top i_daa_target_top (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .scl_i            (scl),
    .sda_i            (sda_bus),
    .sda_oe_o         (sda_oe),
    .pid_i            (pid),
    .bcr_i            (bcr),
    .dcr_i            (dcr),
    .start_daa_i      (start_daa),
    .done_daa_o       (done_daa),
    .dyn_addr_o       (dyn_addr),
    .dyn_addr_valid_o (dyn_addr_valid)
  );

  // Strobes counted mid cycle
  always @(negedge clk) begin
    if (done_daa) begin
      done_pulses <= done_pulses + 1;
    end
    if (dyn_addr_valid) begin
      strobes     <= strobes + 1;
      strobe_addr <= dyn_addr;
    end
  end

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s expected %0b actual %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_byte(input string what, input logic [6:0] exp, input logic [6:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_id(input string what, input logic [ID_BITS-1:0] exp,
                          input logic [ID_BITS-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_state_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s expected %0b actual %0b", test_name, what, exp, act);
    end
  endtask

  `include "daa_tb_tasks.svh"

  initial begin
    void'($urandom(4350));
    rst_n     = 1'b0;
    scl       = 1'b1;
    sda_ctl   = 1'b1;
    pid       = '0;
    bcr       = '0;
    dcr       = '0;
    start_daa = 1'b0;
    test_name = "reset";
    wait_clocks(16);
    rst_n = 1'b1;
    wait_clocks(2);
    idle_before_daa();
    fixed_id_daa();
    wrong_rsvd_byte();
    lost_arbitration();
    bad_parity();
    random_ids();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+verification
verilog/daa_pkg.sv
verilog/bus_monitor.sv
verilog/bus_rx.sv
verilog/bus_tx.sv
verilog/ccc_entdaa.sv
verilog/daa_target_top.sv
verification/daa_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= daa_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
